// ==== hw/apb_periph_decode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "periph_settings.svh"

module apb_periph_decode (
   input  wire                              i_psel,
   input  wire                              i_penable,
   input  wire                              i_pwrite,
   input  wire periph_bus_pkg::apb_addr_t   i_paddr,
   output periph_bus_pkg::periph_sel_t      o_sel,
   output periph_regs_pkg::reg_idx_t        o_reg_idx,
   output logic                             o_addr_err,
   output logic                             o_pready,
   output logic                             o_wr_gpio,
   output logic                             o_wr_pwm0,
   output logic                             o_wr_pwm1,
   output logic                             o_wr_tmr
);

   // Region numbers from the base addresses
   localparam logic [1:0] RGN_GPIO  = 2'(`PERIPH_GPIO_BASE >> 8);
   localparam logic [1:0] RGN_PWM0  = 2'(`PERIPH_PWM0_BASE >> 8);
   localparam logic [1:0] RGN_PWM1  = 2'(`PERIPH_PWM1_BASE >> 8);
   localparam logic [1:0] RGN_TIMER = 2'(`PERIPH_TIMER_BASE >> 8);

   logic [1:0] region;
   logic       wr_acc;

   assign region = i_paddr[9:8];

   // Anything above the four regions is out of map
   assign o_addr_err = |i_paddr[`PERIPH_ADDR_W-1:10];

   // Zero wait states, every access cycle completes
   assign o_pready = i_psel & i_penable;

   always_comb begin
      o_sel = periph_bus_pkg::SEL_GPIO;
      case (region)
         RGN_GPIO:  o_sel = periph_bus_pkg::SEL_GPIO;
         RGN_PWM0:  o_sel = periph_bus_pkg::SEL_PWM0;
         RGN_PWM1:  o_sel = periph_bus_pkg::SEL_PWM1;
         RGN_TIMER: o_sel = periph_bus_pkg::SEL_TIMER;
         default:   o_sel = periph_bus_pkg::SEL_GPIO;
      endcase
   end

   // Offsets 0x20 and up land on slot 7, which no block decodes
   assign o_reg_idx = (|i_paddr[7:5]) ? '1 : i_paddr[4:2];

   // Write strobes, one access cycle wide
   assign wr_acc    = o_pready & i_pwrite & ~o_addr_err;
   assign o_wr_gpio = wr_acc & (o_sel == periph_bus_pkg::SEL_GPIO);
   assign o_wr_pwm0 = wr_acc & (o_sel == periph_bus_pkg::SEL_PWM0);
   assign o_wr_pwm1 = wr_acc & (o_sel == periph_bus_pkg::SEL_PWM1);
   assign o_wr_tmr  = wr_acc & (o_sel == periph_bus_pkg::SEL_TIMER);

endmodule

`default_nettype wire

// ==== hw/apb_read_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_read_result (
   input  wire periph_bus_pkg::periph_sel_t i_sel,
   input  wire                              i_addr_err,
   input  wire periph_bus_pkg::apb_data_t   i_rdata_gpio,
   input  wire periph_bus_pkg::apb_data_t   i_rdata_pwm0,
   input  wire periph_bus_pkg::apb_data_t   i_rdata_pwm1,
   input  wire periph_bus_pkg::apb_data_t   i_rdata_tmr,
   input  wire                              i_pready,
   output periph_bus_pkg::apb_data_t        o_prdata,
   output logic                             o_pslverr
);

   periph_bus_pkg::apb_data_t rdata_sel;

   // Region mux
   always_comb begin
      case (i_sel)
         periph_bus_pkg::SEL_GPIO:  rdata_sel = i_rdata_gpio;
         periph_bus_pkg::SEL_PWM0:  rdata_sel = i_rdata_pwm0;
         periph_bus_pkg::SEL_PWM1:  rdata_sel = i_rdata_pwm1;
         periph_bus_pkg::SEL_TIMER: rdata_sel = i_rdata_tmr;
         default:                   rdata_sel = '0;
      endcase
   end

   // Out-of-map access returns zero data
   assign o_prdata = i_addr_err ? '0 : rdata_sel;

   // Error only in the completing cycle
   assign o_pslverr = i_pready & i_addr_err;

endmodule

`default_nettype wire

// ==== hw/gpio_regs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "periph_settings.svh"

module gpio_regs (
   input  wire                              clk,
   input  wire                              i_rst_n,
   input  wire                              i_wr,
   input  wire periph_regs_pkg::reg_idx_t   i_reg_idx,
   input  wire periph_bus_pkg::apb_data_t   i_wdata,
   input  wire periph_regs_pkg::gpio_word_t i_pins,
   output periph_bus_pkg::apb_data_t        o_rdata,
   output periph_regs_pkg::gpio_word_t      o_gpio_out,
   output periph_regs_pkg::gpio_word_t      o_gpio_oe,
   output logic                             o_gpio_irq
);

   localparam periph_regs_pkg::reg_idx_t IDX_OUT  = periph_regs_pkg::ofs_to_idx(`GPIO_OUT_OFS);
   localparam periph_regs_pkg::reg_idx_t IDX_OE   = periph_regs_pkg::ofs_to_idx(`GPIO_OE_OFS);
   localparam periph_regs_pkg::reg_idx_t IDX_IN   = periph_regs_pkg::ofs_to_idx(`GPIO_IN_OFS);
   localparam periph_regs_pkg::reg_idx_t IDX_MASK = periph_regs_pkg::ofs_to_idx(`GPIO_MASK_OFS);
   localparam periph_regs_pkg::reg_idx_t IDX_STAT = periph_regs_pkg::ofs_to_idx(`GPIO_STAT_OFS);

   periph_regs_pkg::gpio_word_t out_q;
   periph_regs_pkg::gpio_word_t oe_q;
   periph_regs_pkg::gpio_word_t mask_q;
   periph_regs_pkg::gpio_word_t stat_q;
   periph_regs_pkg::gpio_word_t sync1_q;
   periph_regs_pkg::gpio_word_t sync2_q;
   periph_regs_pkg::gpio_word_t prev_q;
   periph_regs_pkg::gpio_word_t chg;
   periph_regs_pkg::gpio_word_t stat_clr;

   // ==========================================================
   // Pin synchroniser and edge detect
   // ==========================================================
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sync1_q <= '0;
         sync2_q <= '0;
         prev_q  <= '0;
      end else begin
         sync1_q <= i_pins;
         sync2_q <= sync1_q;
         prev_q  <= sync2_q;
      end
   end

   // Either edge counts, only on unmasked pins... i.e. mask bit set
   assign chg      = (sync2_q ^ prev_q) & mask_q;
   assign stat_clr = (i_wr && i_reg_idx == IDX_STAT) ? i_wdata[`PERIPH_GPIO_W-1:0] : '0;

   // ==========================================================
   // Registers
   // ==========================================================
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         out_q  <= '0;
         oe_q   <= '0;
         mask_q <= '0;
         stat_q <= '0;
      end else begin
         if (i_wr) begin
            case (i_reg_idx)
               IDX_OUT:  out_q  <= i_wdata[`PERIPH_GPIO_W-1:0];
               IDX_OE:   oe_q   <= i_wdata[`PERIPH_GPIO_W-1:0];
               IDX_MASK: mask_q <= i_wdata[`PERIPH_GPIO_W-1:0];
               default: ;
            endcase
         end
         // New edge beats a clear of the same bit
         stat_q <= (stat_q & ~stat_clr) | chg;
      end
   end

   always_comb begin
      case (i_reg_idx)
         IDX_OUT:  o_rdata = periph_bus_pkg::apb_data_t'(out_q);
         IDX_OE:   o_rdata = periph_bus_pkg::apb_data_t'(oe_q);
         IDX_IN:   o_rdata = periph_bus_pkg::apb_data_t'(sync2_q);
         IDX_MASK: o_rdata = periph_bus_pkg::apb_data_t'(mask_q);
         IDX_STAT: o_rdata = periph_bus_pkg::apb_data_t'(stat_q);
         default:  o_rdata = '0;
      endcase
   end

   assign o_gpio_out = out_q;
   assign o_gpio_oe  = oe_q;
   assign o_gpio_irq = |stat_q;

endmodule

`default_nettype wire

// ==== hw/machine_timer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "periph_settings.svh"

module machine_timer (
   input  wire                            clk,
   input  wire                            i_rst_n,
   input  wire                            i_wr,
   input  wire periph_regs_pkg::reg_idx_t i_reg_idx,
   input  wire periph_bus_pkg::apb_data_t i_wdata,
   output periph_bus_pkg::apb_data_t      o_rdata,
   output logic                           o_timer_irq
);

   localparam periph_regs_pkg::reg_idx_t IDX_COUNT = periph_regs_pkg::ofs_to_idx(`TMR_COUNT_OFS);
   localparam periph_regs_pkg::reg_idx_t IDX_CMP   = periph_regs_pkg::ofs_to_idx(`TMR_CMP_OFS);
   localparam periph_regs_pkg::reg_idx_t IDX_CTRL  = periph_regs_pkg::ofs_to_idx(`TMR_CTRL_OFS);

   periph_regs_pkg::tmr_word_t count_q;
   periph_regs_pkg::tmr_word_t count_d;
   periph_regs_pkg::tmr_word_t cmp_q;
   periph_regs_pkg::tmr_word_t cmp_d;
   logic                       en_q;
   logic                       en_d;
   logic                       irq_q;

   // Bus write to COUNT wins over the increment
   always_comb begin
      count_d = count_q;
      cmp_d   = cmp_q;
      en_d    = en_q;
      if (en_q) begin
         count_d = count_q + 1'b1;
      end
      if (i_wr) begin
         case (i_reg_idx)
            IDX_COUNT: count_d = i_wdata;
            IDX_CMP:   cmp_d   = i_wdata;
            IDX_CTRL:  en_d    = i_wdata[0];
            default: ;
         endcase
      end
   end

   // Irq flop sees next-state values so it tracks the registers exactly
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         count_q <= '0;
         cmp_q   <= '0;
         en_q    <= 1'b0;
         irq_q   <= 1'b0;
      end else begin
         count_q <= count_d;
         cmp_q   <= cmp_d;
         en_q    <= en_d;
         irq_q   <= en_d && (count_d >= cmp_d);
      end
   end

   always_comb begin
      case (i_reg_idx)
         IDX_COUNT: o_rdata = count_q;
         IDX_CMP:   o_rdata = cmp_q;
         IDX_CTRL:  o_rdata = periph_bus_pkg::apb_data_t'(en_q);
         default:   o_rdata = '0;
      endcase
   end

   assign o_timer_irq = irq_q;

endmodule

`default_nettype wire

// ==== hw/periph_bus_pkg.sv ====
`default_nettype none
`include "periph_settings.svh"

package periph_bus_pkg;

   // ==========================================================
   // APB side
   // ==========================================================

   // Address and data words as seen on the APB port
   typedef logic [`PERIPH_ADDR_W-1:0] apb_addr_t;
   typedef logic [`PERIPH_DATA_W-1:0] apb_data_t;

   // Addressed peripheral
   // one per 256-byte region of the map
   typedef enum logic [1:0] {
      SEL_GPIO  = 2'd0,
      SEL_PWM0  = 2'd1,
      SEL_PWM1  = 2'd2,
      SEL_TIMER = 2'd3
   } periph_sel_t;

endpackage

`default_nettype wire

// ==== hw/periph_regs_pkg.sv ====
`default_nettype none
`include "periph_settings.svh"

package periph_regs_pkg;

   // ==========================================================
   // Register side
   // ==========================================================

   // Word index inside a region, address bits 4:2
   typedef logic [2:0] reg_idx_t;

   // PWM counter, period and duty
   typedef logic [`PERIPH_PWM_W-1:0] pwm_cnt_t;

   // One bit per GPIO pin
   typedef logic [`PERIPH_GPIO_W-1:0] gpio_word_t;

   // Timer count and compare word
   typedef logic [`PERIPH_DATA_W-1:0] tmr_word_t;

   // Byte offset of a register to its word index
   function automatic reg_idx_t ofs_to_idx(input int unsigned ofs);
      return reg_idx_t'(ofs >> 2);
   endfunction

endpackage

`default_nettype wire

// ==== hw/periph_settings.svh ====
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// Bus and datapath widths
`define PERIPH_DATA_W      32
`define PERIPH_ADDR_W      12
`define PERIPH_GPIO_W      16
`define PERIPH_PWM_W       16

// Region bases, 256 bytes each, picked by address bits 9:8
`define PERIPH_GPIO_BASE   'h000
`define PERIPH_PWM0_BASE   'h100
`define PERIPH_PWM1_BASE   'h200
`define PERIPH_TIMER_BASE  'h300

// GPIO register map
`define GPIO_OUT_OFS       'h00
`define GPIO_OE_OFS        'h04
`define GPIO_IN_OFS        'h08
`define GPIO_MASK_OFS      'h0C
`define GPIO_STAT_OFS      'h10

// PWM channel register map
`define PWM_PERIOD_OFS     'h00
`define PWM_DUTY_OFS       'h04
`define PWM_EN_OFS         'h08

// Machine timer register map
`define TMR_COUNT_OFS      'h00
`define TMR_CMP_OFS        'h04
`define TMR_CTRL_OFS       'h08

`endif

// ==== hw/periph_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module periph_subsystem (
   input  wire                              clk,
   input  wire                              i_rst_n,
   input  wire                              i_psel,
   input  wire                              i_penable,
   input  wire                              i_pwrite,
   input  wire periph_bus_pkg::apb_addr_t   i_paddr,
   input  wire periph_bus_pkg::apb_data_t   i_pwdata,
   input  wire periph_regs_pkg::gpio_word_t i_gpio_in,
   output periph_bus_pkg::apb_data_t        o_prdata,
   output logic                             o_pready,
   output logic                             o_pslverr,
   output periph_regs_pkg::gpio_word_t      o_gpio_out,
   output periph_regs_pkg::gpio_word_t      o_gpio_oe,
   output logic                             o_gpio_irq,
   output logic                             o_servo_pwm,
   output logic                             o_motor_pwm,
   output logic                             o_timer_irq
);

   periph_bus_pkg::periph_sel_t sel;
   periph_regs_pkg::reg_idx_t   reg_idx;
   logic                        addr_err;
   logic                        wr_gpio;
   logic                        wr_pwm0;
   logic                        wr_pwm1;
   logic                        wr_tmr;
   periph_bus_pkg::apb_data_t   rdata_gpio;
   periph_bus_pkg::apb_data_t   rdata_pwm0;
   periph_bus_pkg::apb_data_t   rdata_pwm1;
   periph_bus_pkg::apb_data_t   rdata_tmr;

   // ==========================================================
   // Decode
   // ==========================================================
   apb_periph_decode decode0 (
      .i_psel     (i_psel),
      .i_penable  (i_penable),
      .i_pwrite   (i_pwrite),
      .i_paddr    (i_paddr),
      .o_sel      (sel),
      .o_reg_idx  (reg_idx),
      .o_addr_err (addr_err),
      .o_pready   (o_pready),
      .o_wr_gpio  (wr_gpio),
      .o_wr_pwm0  (wr_pwm0),
      .o_wr_pwm1  (wr_pwm1),
      .o_wr_tmr   (wr_tmr)
   );

   // ==========================================================
   // Register blocks
   // ==========================================================
   gpio_regs gpio0 (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_wr       (wr_gpio),
      .i_reg_idx  (reg_idx),
      .i_wdata    (i_pwdata),
      .i_pins     (i_gpio_in),
      .o_rdata    (rdata_gpio),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_gpio_irq (o_gpio_irq)
   );

   // Servo channel
   pwm_channel pwm_servo (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_wr      (wr_pwm0),
      .i_reg_idx (reg_idx),
      .i_wdata   (i_pwdata),
      .o_rdata   (rdata_pwm0),
      .o_pwm     (o_servo_pwm)
   );

   // DC motor channel
   pwm_channel pwm_motor (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_wr      (wr_pwm1),
      .i_reg_idx (reg_idx),
      .i_wdata   (i_pwdata),
      .o_rdata   (rdata_pwm1),
      .o_pwm     (o_motor_pwm)
   );

   machine_timer timer0 (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_wr        (wr_tmr),
      .i_reg_idx   (reg_idx),
      .i_wdata     (i_pwdata),
      .o_rdata     (rdata_tmr),
      .o_timer_irq (o_timer_irq)
   );

   // Read data and error back to the master
   apb_read_result result0 (
      .i_sel        (sel),
      .i_addr_err   (addr_err),
      .i_rdata_gpio (rdata_gpio),
      .i_rdata_pwm0 (rdata_pwm0),
      .i_rdata_pwm1 (rdata_pwm1),
      .i_rdata_tmr  (rdata_tmr),
      .i_pready     (o_pready),
      .o_prdata     (o_prdata),
      .o_pslverr    (o_pslverr)
   );

endmodule

`default_nettype wire

// ==== hw/pwm_channel.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "periph_settings.svh"

module pwm_channel (
   input  wire                            clk,
   input  wire                            i_rst_n,
   input  wire                            i_wr,
   input  wire periph_regs_pkg::reg_idx_t i_reg_idx,
   input  wire periph_bus_pkg::apb_data_t i_wdata,
   output periph_bus_pkg::apb_data_t      o_rdata,
   output logic                           o_pwm
);

   localparam periph_regs_pkg::reg_idx_t IDX_PERIOD =
      periph_regs_pkg::ofs_to_idx(`PWM_PERIOD_OFS);
   localparam periph_regs_pkg::reg_idx_t IDX_DUTY = periph_regs_pkg::ofs_to_idx(`PWM_DUTY_OFS);
   localparam periph_regs_pkg::reg_idx_t IDX_EN   = periph_regs_pkg::ofs_to_idx(`PWM_EN_OFS);

   periph_regs_pkg::pwm_cnt_t period_q;
   periph_regs_pkg::pwm_cnt_t duty_q;
   periph_regs_pkg::pwm_cnt_t cnt_q;
   logic                      en_q;
   logic                      pwm_q;
   logic [`PERIPH_PWM_W:0]    cnt_inc;
   logic                      wrap;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         period_q <= '0;
         duty_q   <= '0;
         en_q     <= 1'b0;
      end else if (i_wr) begin
         case (i_reg_idx)
            IDX_PERIOD: period_q <= i_wdata[`PERIPH_PWM_W-1:0];
            IDX_DUTY:   duty_q   <= i_wdata[`PERIPH_PWM_W-1:0];
            IDX_EN:     en_q     <= i_wdata[0];
            default: ;
         endcase
      end
   end

   // ==========================================================
   // Counter 0 .. period-1 and output level
   // ==========================================================
   // Extra bit so the compare never overflows; period 0 keeps cnt at 0
   assign cnt_inc = {1'b0, cnt_q} + 1'b1;
   assign wrap    = cnt_inc >= {1'b0, period_q};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt_q <= '0;
         pwm_q <= 1'b0;
      end else begin
         if (!en_q || wrap) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_inc[`PERIPH_PWM_W-1:0];
         end
         pwm_q <= en_q && (cnt_q < duty_q);
      end
   end

   always_comb begin
      case (i_reg_idx)
         IDX_PERIOD: o_rdata = periph_bus_pkg::apb_data_t'(period_q);
         IDX_DUTY:   o_rdata = periph_bus_pkg::apb_data_t'(duty_q);
         IDX_EN:     o_rdata = periph_bus_pkg::apb_data_t'(en_q);
         default:    o_rdata = '0;
      endcase
   end

   assign o_pwm = pwm_q;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_periph_subsystem -f src.f -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/Vtb_periph_subsystem
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit "$status"
fi

exit 0

// ==== src.f ====
+incdir+hw
hw/periph_bus_pkg.sv
hw/periph_regs_pkg.sv
hw/apb_periph_decode.sv
hw/gpio_regs.sv
hw/pwm_channel.sv
hw/machine_timer.sv
hw/apb_read_result.sv
hw/periph_subsystem.sv
tb/periph_checker.sv
tb/tb_periph_subsystem.sv

// ==== tb/periph_checker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "periph_settings.svh"

module periph_checker (
   input wire                            clk,
   input wire                            i_rst_n,
   input wire                            i_psel,
   input wire                            i_penable,
   input wire                            i_pwrite,
   input wire periph_bus_pkg::apb_addr_t i_paddr,
   input wire periph_bus_pkg::apb_data_t i_pwdata,
   input wire                            i_pready,
   input wire                            i_pslverr,
   input wire                            i_gpio_irq,
   input wire                            i_timer_irq
);

   localparam periph_bus_pkg::apb_addr_t CTRL_ADDR =
      periph_bus_pkg::apb_addr_t'(`PERIPH_TIMER_BASE + `TMR_CTRL_OFS);

   logic wr_acc;
   logic tmr_en_q;
   int   fail_cnt = 0;

   assign wr_acc = i_psel & i_penable & i_pwrite;

   // Shadow of timer CTRL bit 0 rebuilt from bus writes
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         tmr_en_q <= 1'b0;
      end else if (wr_acc && i_paddr[`PERIPH_ADDR_W-1:2] == CTRL_ADDR[`PERIPH_ADDR_W-1:2]) begin
         tmr_en_q <= i_pwdata[0];
      end
   end

   // ==========================================================
   // APB response
   // ==========================================================
   a_pready: assert property (@(posedge clk) i_pready == (i_psel && i_penable))
      else begin
         fail_cnt++;
         $error("PREADY does not follow PSEL and PENABLE");
      end

   a_slverr: assert property (@(posedge clk) i_pslverr |-> i_pready)
      else begin
         fail_cnt++;
         $error("PSLVERR high outside an access cycle");
      end

   // ==========================================================
   // Interrupts
   // ==========================================================
   a_gpio_irq: assert property (@(posedge clk) disable iff (!i_rst_n)
      $fell(i_gpio_irq) |-> $past(wr_acc))
      else begin
         fail_cnt++;
         $error("GPIO interrupt dropped without a write access");
      end

   a_timer_irq: assert property (@(posedge clk) disable iff (!i_rst_n)
      !tmr_en_q |-> !i_timer_irq)
      else begin
         fail_cnt++;
         $error("Timer interrupt high while the timer is disabled");
      end

endmodule

`default_nettype wire

// ==== tb/tb_periph_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "periph_settings.svh"

module tb_periph_subsystem;

   localparam int CLK_PERIOD     = 8;
   localparam int TIMEOUT_CYCLES = 3000;

   logic                        clk;
   logic                        rst_n;
   logic                        psel;
   logic                        penable;
   logic                        pwrite;
   periph_bus_pkg::apb_addr_t   paddr;
   periph_bus_pkg::apb_data_t   pwdata;
   periph_regs_pkg::gpio_word_t gpio_in;
   periph_bus_pkg::apb_data_t   prdata;
   logic                        pready;
   logic                        pslverr;
   periph_regs_pkg::gpio_word_t gpio_out;
   periph_regs_pkg::gpio_word_t gpio_oe;
   logic                        gpio_irq;
   logic                        servo_pwm;
   logic                        motor_pwm;
   logic                        timer_irq;

   integer                      seed;
   int                          cycle_cnt = 0;
   periph_bus_pkg::apb_data_t   rdata;
   logic                        err;
   periph_bus_pkg::apb_data_t   out_val;
   periph_bus_pkg::apb_data_t   oe_val;
   periph_bus_pkg::apb_data_t   cmp_val;
   periph_bus_pkg::apb_data_t   scratch;
   periph_regs_pkg::gpio_word_t mask_val;
   periph_regs_pkg::gpio_word_t pins_val;
   int                          base;
   int                          period;
   int                          duty;
   int                          high_cnt;
   int                          wait_cnt;

   periph_subsystem dut0 (
      .clk         (clk),
      .i_rst_n     (rst_n),
      .i_psel      (psel),
      .i_penable   (penable),
      .i_pwrite    (pwrite),
      .i_paddr     (paddr),
      .i_pwdata    (pwdata),
      .i_gpio_in   (gpio_in),
      .o_prdata    (prdata),
      .o_pready    (pready),
      .o_pslverr   (pslverr),
      .o_gpio_out  (gpio_out),
      .o_gpio_oe   (gpio_oe),
      .o_gpio_irq  (gpio_irq),
      .o_servo_pwm (servo_pwm),
      .o_motor_pwm (motor_pwm),
      .o_timer_irq (timer_irq)
   );

   bind periph_subsystem periph_checker chk0 (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_psel      (i_psel),
      .i_penable   (i_penable),
      .i_pwrite    (i_pwrite),
      .i_paddr     (i_paddr),
      .i_pwdata    (i_pwdata),
      .i_pready    (o_pready),
      .i_pslverr   (o_pslverr),
      .i_gpio_irq  (o_gpio_irq),
      .i_timer_irq (o_timer_irq)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests still running after %0d cycles", cycle_cnt);
         $display("Some tests failed");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   // ==========================================================
   // Checks and bus tasks
   // ==========================================================
   task automatic report_error(input string msg);
      $display("Fail at %0t: %s", $time, msg);
      $display("Some tests failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
         else report_error($sformatf("%s is 0x%08h, expected 0x%08h", what, got, exp));
   endtask

   task automatic check_true(input string what, input logic cond);
      assert (cond === 1'b1)
         else report_error(what);
   endtask

   function automatic periph_bus_pkg::apb_addr_t reg_addr(input int rbase, input int ofs);
      return periph_bus_pkg::apb_addr_t'(rbase + ofs);
   endfunction

   function automatic logic pwm_level(input int ch);
      return (ch == 0) ? servo_pwm : motor_pwm;
   endfunction

   // Setup cycle then access until PREADY
   task automatic apb_transfer(input logic write, input periph_bus_pkg::apb_addr_t addr,
                               input periph_bus_pkg::apb_data_t wdata,
                               output periph_bus_pkg::apb_data_t data_out,
                               output logic err_out);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      while (!pready) begin
         @(negedge clk);
      end
      data_out = prdata;
      err_out  = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_write(input periph_bus_pkg::apb_addr_t addr,
                            input periph_bus_pkg::apb_data_t wdata);
      periph_bus_pkg::apb_data_t dummy;
      logic                      werr;
      apb_transfer(1'b1, addr, wdata, dummy, werr);
      check_equal($sformatf("PSLVERR of write to 0x%03h", addr), 32'(werr), 32'd0);
   endtask

   task automatic expect_read(input periph_bus_pkg::apb_addr_t addr,
                              input periph_bus_pkg::apb_data_t exp);
      periph_bus_pkg::apb_data_t got;
      logic                      rerr;
      apb_transfer(1'b0, addr, '0, got, rerr);
      check_equal($sformatf("PSLVERR of read at 0x%03h", addr), 32'(rerr), 32'd0);
      check_equal($sformatf("Read at 0x%03h", addr), got, exp);
   endtask

   // Random word in and masked word back
   task automatic write_readback(input periph_bus_pkg::apb_addr_t addr,
                                 input periph_bus_pkg::apb_data_t mask,
                                 output periph_bus_pkg::apb_data_t val);
      val = $random(seed);
      apb_write(addr, val);
      val = val & mask;
      expect_read(addr, val);
   endtask

   task automatic expect_slverr(input logic write, input periph_bus_pkg::apb_addr_t addr);
      periph_bus_pkg::apb_data_t got;
      logic                      xerr;
      apb_transfer(write, addr, $random(seed), got, xerr);
      check_equal($sformatf("PSLVERR at unmapped 0x%03h", addr), 32'(xerr), 32'd1);
      check_equal($sformatf("PRDATA at unmapped 0x%03h", addr), got, 32'd0);
   endtask

   task automatic count_high(input int ch, input int cycles, output int n);
      n = 0;
      repeat (cycles) begin
         @(negedge clk);
         if (pwm_level(ch)) begin
            n++;
         end
      end
   endtask

   // ==========================================================
   // Stimulus
   // ==========================================================
   initial begin
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      gpio_in = '0;
      seed    = 32'hdf6f_1939;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      // Reset state of every mapped register and output
      for (int i = 0; i < 5; i++) begin
         expect_read(reg_addr(`PERIPH_GPIO_BASE, 4 * i), '0);
      end
      for (int i = 0; i < 3; i++) begin
         expect_read(reg_addr(`PERIPH_PWM0_BASE, 4 * i), '0);
         expect_read(reg_addr(`PERIPH_PWM1_BASE, 4 * i), '0);
         expect_read(reg_addr(`PERIPH_TIMER_BASE, 4 * i), '0);
      end
      @(negedge clk);
      check_true("Outputs not low after reset", gpio_out == '0 && gpio_oe == '0 &&
                 !gpio_irq && !servo_pwm && !motor_pwm && !timer_irq);

      // Random register values
      write_readback(reg_addr(`PERIPH_GPIO_BASE, `GPIO_OUT_OFS), 32'h0000_ffff, out_val);
      write_readback(reg_addr(`PERIPH_GPIO_BASE, `GPIO_OE_OFS), 32'h0000_ffff, oe_val);
      write_readback(reg_addr(`PERIPH_GPIO_BASE, `GPIO_MASK_OFS), 32'h0000_ffff, scratch);
      @(negedge clk);
      check_equal("o_gpio_out", 32'(gpio_out), out_val);
      check_equal("o_gpio_oe", 32'(gpio_oe), oe_val);
      for (int ch = 0; ch < 2; ch++) begin
         base = (ch == 0) ? `PERIPH_PWM0_BASE : `PERIPH_PWM1_BASE;
         write_readback(reg_addr(base, `PWM_PERIOD_OFS), 32'h0000_ffff, scratch);
         write_readback(reg_addr(base, `PWM_DUTY_OFS), 32'h0000_ffff, scratch);
         write_readback(reg_addr(base, `PWM_EN_OFS), 32'h0000_0001, scratch);
      end
      write_readback(reg_addr(`PERIPH_TIMER_BASE, `TMR_CMP_OFS), 32'hffff_ffff, cmp_val);

      // 0x400 would alias GPIO OUT and 0xB04 the timer compare if bits 11:10 were ignored
      expect_slverr(1'b0, 12'h400);
      expect_slverr(1'b1, 12'h400);
      expect_slverr(1'b1, 12'hb04);
      expect_read(reg_addr(`PERIPH_GPIO_BASE, `GPIO_OUT_OFS), out_val);
      expect_read(reg_addr(`PERIPH_TIMER_BASE, `TMR_CMP_OFS), cmp_val);

      // ==========================================================
      // GPIO input change interrupt
      // ==========================================================
      scratch  = $random(seed);
      mask_val = scratch[15:0] | 16'h0001;
      apb_write(reg_addr(`PERIPH_GPIO_BASE, `GPIO_MASK_OFS), 32'(mask_val));
      scratch  = $random(seed);
      pins_val = scratch[15:0] | 16'h0001;
      @(posedge clk);
      gpio_in <= pins_val;
      repeat (5) @(posedge clk);
      expect_read(reg_addr(`PERIPH_GPIO_BASE, `GPIO_IN_OFS), 32'(pins_val));
      expect_read(reg_addr(`PERIPH_GPIO_BASE, `GPIO_STAT_OFS), 32'(pins_val & mask_val));
      @(negedge clk);
      check_true("o_gpio_irq low after a masked pin change", gpio_irq);
      apb_write(reg_addr(`PERIPH_GPIO_BASE, `GPIO_STAT_OFS), 32'(pins_val & mask_val));
      expect_read(reg_addr(`PERIPH_GPIO_BASE, `GPIO_STAT_OFS), '0);
      @(negedge clk);
      check_true("o_gpio_irq still high after STAT clear", !gpio_irq);

      // ==========================================================
      // PWM duty over one period
      // ==========================================================
      for (int ch = 0; ch < 2; ch++) begin
         base   = (ch == 0) ? `PERIPH_PWM0_BASE : `PERIPH_PWM1_BASE;
         period = 4 + ({$random(seed)} % 37);
         duty   = {$random(seed)} % (period + 3);
         apb_write(reg_addr(base, `PWM_PERIOD_OFS), period);
         apb_write(reg_addr(base, `PWM_DUTY_OFS), duty);
         apb_write(reg_addr(base, `PWM_EN_OFS), 32'd1);
         repeat (2 * period) @(negedge clk);
         count_high(ch, period, high_cnt);
         check_equal($sformatf("PWM%0d high cycles, period %0d duty %0d", ch, period, duty),
                     high_cnt, (duty < period) ? duty : period);
         apb_write(reg_addr(base, `PWM_EN_OFS), 32'd0);
         repeat (2) @(negedge clk);
         check_true($sformatf("PWM%0d output high after disable", ch), !pwm_level(ch));
      end

      // Timer compare at 50
      apb_write(reg_addr(`PERIPH_TIMER_BASE, `TMR_COUNT_OFS), 32'd0);
      apb_write(reg_addr(`PERIPH_TIMER_BASE, `TMR_CMP_OFS), 32'd50);
      apb_write(reg_addr(`PERIPH_TIMER_BASE, `TMR_CTRL_OFS), 32'd1);
      @(negedge clk);
      check_true("o_timer_irq high right after enable", !timer_irq);
      wait_cnt = 0;
      while (!timer_irq && wait_cnt < 60) begin
         @(negedge clk);
         wait_cnt++;
      end
      check_true("o_timer_irq not set within 60 cycles", timer_irq);
      apb_transfer(1'b0, reg_addr(`PERIPH_TIMER_BASE, `TMR_COUNT_OFS), '0, rdata, err);
      check_true($sformatf("Timer COUNT 0x%08h below compare or PSLVERR set", rdata),
                 rdata >= 32'd50 && !err);

      if (dut0.chk0.fail_cnt == 0) begin
         $display("All tests passed");
         $finish;
      end else begin
         $display("Protocol checker flagged %0d assertion failures", dut0.chk0.fail_cnt);
         $display("Some tests failed");
         $fatal(1, "protocol assertions failed");
      end
   end

endmodule

`default_nettype wire
